/* source/maf_pkg.sv */
package maf_pkg;

	// history depth, sized for the largest window
	localparam int HIST_DEPTH = 16;

	// extra sum bits so 16 full-scale samples never wrap
	localparam int SUM_GROWTH = $clog2(HIST_DEPTH);

	// tap count runs 2..16, so one bit more than the growth
	localparam int TAP_CNT_W = SUM_GROWTH + 1;

	// shift amount runs 0..4
	localparam int SHIFT_W = $clog2(SUM_GROWTH + 1);

	// width of the window select input
	localparam int SEL_W = 3;

	// select codes seen on filt_sel
	localparam logic [SEL_W-1:0] SEL_WIN2 = 3'b000;
	localparam logic [SEL_W-1:0] SEL_WIN3 = 3'b001;
	localparam logic [SEL_W-1:0] SEL_WIN4 = 3'b010;
	localparam logic [SEL_W-1:0] SEL_WIN8 = 3'b011;
	// every code from 100 up folds onto the 16 window

	// decoded window choice
	typedef enum logic [2:0] {
		WIN_2  = 3'd0,
		WIN_3  = 3'd1,
		WIN_4  = 3'd2,
		WIN_8  = 3'd3,
		WIN_16 = 3'd4
	} window_e;

	// taps summed for each window
	localparam logic [TAP_CNT_W-1:0] TAPS_WIN2  = 5'd2;
	localparam logic [TAP_CNT_W-1:0] TAPS_WIN3  = 5'd3;
	localparam logic [TAP_CNT_W-1:0] TAPS_WIN4  = 5'd4;
	localparam logic [TAP_CNT_W-1:0] TAPS_WIN8  = 5'd8;
	localparam logic [TAP_CNT_W-1:0] TAPS_WIN16 = 5'd16;

	// log2 divisor for the power-of-two windows
	localparam logic [SHIFT_W-1:0] SHIFT_WIN2  = 3'd1;
	localparam logic [SHIFT_W-1:0] SHIFT_WIN4  = 3'd2;
	localparam logic [SHIFT_W-1:0] SHIFT_WIN8  = 3'd3;
	localparam logic [SHIFT_W-1:0] SHIFT_WIN16 = 3'd4;
	// window of 3 divides instead, shift stays 0
	localparam logic [SHIFT_W-1:0] SHIFT_NONE  = 3'd0;

endpackage

/* source/filt_cfg_if.sv */
`timescale 1ns/10ps

interface filt_cfg_if import maf_pkg::*; ();

	// decoded window, also the source for the fields below
	window_e window;

	// number of newest taps in the sum, 2..16
	logic [TAP_CNT_W-1:0] tap_count;

	// arithmetic right shift for power-of-two windows
	logic [SHIFT_W-1:0] shift_amt;

	// window of 3, divide rather than shift
	logic div3;

	// decode stage owns every field
	modport decoder (
		output window,
		output tap_count,
		output shift_amt,
		output div3
	);

	// execute stage only needs the tap mask length
	modport datapath (input tap_count);

	// result stage picks between divide and shift
	modport scaler (input shift_amt, input div3);

endinterface

/* source/window_decode.sv */
`timescale 1ns/10ps

module window_decode import maf_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [SEL_W-1:0] filt_sel,
	filt_cfg_if.decoder cfg
);

	// captured select, config follows it from the same edge
	logic [SEL_W-1:0] sel_r;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// back to the 2 window
			sel_r <= SEL_WIN2;
		end else begin
			sel_r <= filt_sel;
		end
	end

	// select code to window, upper half all 16
	always_comb begin
		case (sel_r)
			SEL_WIN2: cfg.window = WIN_2;
			SEL_WIN3: cfg.window = WIN_3;
			SEL_WIN4: cfg.window = WIN_4;
			SEL_WIN8: cfg.window = WIN_8;
			default:  cfg.window = WIN_16;
		endcase
	end

	// window to tap count, shift and divide flag
	always_comb begin
		// defaults match the 2 window
		cfg.tap_count = TAPS_WIN2;
		cfg.shift_amt = SHIFT_WIN2;
		cfg.div3 = 1'b0;
		case (cfg.window)
			WIN_3: begin
				cfg.tap_count = TAPS_WIN3;
				// no shift, divider does the work
				cfg.shift_amt = SHIFT_NONE;
				cfg.div3 = 1'b1;
			end
			WIN_4: begin
				cfg.tap_count = TAPS_WIN4;
				cfg.shift_amt = SHIFT_WIN4;
			end
			WIN_8: begin
				cfg.tap_count = TAPS_WIN8;
				cfg.shift_amt = SHIFT_WIN8;
			end
			WIN_16: begin
				cfg.tap_count = TAPS_WIN16;
				cfg.shift_amt = SHIFT_WIN16;
			end
			default: begin
				// WIN_2, already set above
				cfg.div3 = 1'b0;
			end
		endcase
	end

endmodule

/* source/tap_sum.sv */
`timescale 1ns/10ps

module tap_sum import maf_pkg::*; #(
	parameter int DATA_W = 24
) (
	input logic clk,
	input logic rst_n,
	input logic sclr,
	input logic signed [DATA_W-1:0] d,
	filt_cfg_if.datapath cfg,
	output logic signed [DATA_W+SUM_GROWTH-1:0] sum
);

	localparam int SUM_W = DATA_W + SUM_GROWTH;

	// delay line, index 0 is the newest sample
	logic signed [DATA_W-1:0] taps [HIST_DEPTH];

	// sign-extended copies of the taps
	logic signed [SUM_W-1:0] taps_ext [HIST_DEPTH];

	// which taps are inside the current window
	logic [HIST_DEPTH-1:0] tap_mask;

	// combinational sum ahead of the register
	logic signed [SUM_W-1:0] sum_next;

	// shift one sample in every clock, no strobe
	always_ff @(posedge clk) begin
		if (!rst_n || sclr) begin
			// empty history
			for (int i = 0; i < HIST_DEPTH; i++) begin
				taps[i] <= '0;
			end
		end else begin
			taps[0] <= d;
			for (int i = 1; i < HIST_DEPTH; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// widen each tap with its own sign bit
	always_comb begin
		for (int i = 0; i < HIST_DEPTH; i++) begin
			taps_ext[i] = {{SUM_GROWTH{taps[i][DATA_W-1]}}, taps[i]};
		end
	end

	// newest tap_count taps are in the window
	always_comb begin
		for (int i = 0; i < HIST_DEPTH; i++) begin
			tap_mask[i] = (i < int'(cfg.tap_count));
		end
	end

	// masked adder chain
	// 16 full-scale samples fit thanks to SUM_GROWTH
	always_comb begin
		sum_next = '0;
		for (int i = 0; i < HIST_DEPTH; i++) begin
			if (tap_mask[i]) begin
				sum_next = sum_next + taps_ext[i];
			end
		end
	end

	// sum is one edge behind tap 0
	always_ff @(posedge clk) begin
		if (!rst_n || sclr) begin
			sum <= '0;
		end else begin
			sum <= sum_next;
		end
	end

endmodule

/* source/avg_scale.sv */
`timescale 1ns/10ps

module avg_scale import maf_pkg::*; #(
	parameter int DATA_W = 24
) (
	input logic clk,
	input logic rst_n,
	input logic signed [DATA_W+SUM_GROWTH-1:0] sum,
	filt_cfg_if.scaler cfg,
	output logic signed [DATA_W-1:0] q
);

	localparam int SUM_W = DATA_W + SUM_GROWTH;

	// divisor for the 3 window, kept signed at full sum width
	localparam logic signed [SUM_W-1:0] DIV_THREE = 3;

	// divide path, truncates toward zero
	logic signed [SUM_W-1:0] quot3;

	// shift path, rounds toward minus infinity
	logic signed [SUM_W-1:0] shifted;

	// chosen result at full width
	logic signed [SUM_W-1:0] scaled;

	// output sample before the register
	logic signed [DATA_W-1:0] q_next;

	// signed divide by a constant
	always_comb begin
		quot3 = sum / DIV_THREE;
	end

	// arithmetic shift keeps the sign
	always_comb begin
		shifted = sum >>> cfg.shift_amt;
	end

	// pick divide or shift
	always_comb begin
		if (cfg.div3) begin
			scaled = quot3;
		end else begin
			scaled = shifted;
		end
	end

	// average always lies inside the sample range
	// so the low bits carry it exactly, sign included
	always_comb begin
		q_next = scaled[DATA_W-1:0];
	end

	// q is one edge behind the sum
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q <= '0;
		end else begin
			q <= q_next;
		end
	end

endmodule

/* source/moving_avg_top.sv */
`timescale 1ns/10ps

module moving_avg_top import maf_pkg::*; #(
	parameter int DATA_W = 24
) (
	input logic clk,
	input logic rst_n,
	input logic sclr,
	input logic [SEL_W-1:0] filt_sel,
	input logic signed [DATA_W-1:0] d,
	output logic signed [DATA_W-1:0] q
);

	// registered tap sum, execute to result
	logic signed [DATA_W+SUM_GROWTH-1:0] tap_total;

	// decoded window shared by all three stages
	filt_cfg_if cfg_bus ();

	// decode, filt_sel to window fields
	window_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.filt_sel(filt_sel),
		.cfg(cfg_bus.decoder)
	);

	// execute, delay line and masked sum
	// d at edge E lands in tap 0 at E, sum at E+1
	tap_sum #(
		.DATA_W(DATA_W)
	) u_tap_sum (
		.clk(clk),
		.rst_n(rst_n),
		.sclr(sclr),
		.d(d),
		.cfg(cfg_bus.datapath),
		.sum(tap_total)
	);

	// result, scale and register q at E+2
	avg_scale #(
		.DATA_W(DATA_W)
	) u_avg_scale (
		.clk(clk),
		.rst_n(rst_n),
		.sum(tap_total),
		.cfg(cfg_bus.scaler),
		.q(q)
	);

endmodule

/* tb/moving_avg_asserts.sv */
`timescale 1ns/10ps

module moving_avg_asserts #(
	parameter int DATA_W = 24
) (
	input logic clk,
	input logic rst_n,
	input logic sclr,
	input logic signed [DATA_W-1:0] d,
	input logic signed [DATA_W-1:0] q
);

	// edges seen so far, $past needs two of them
	logic [1:0] edge_cnt = 2'd0;

	// high once reset has been sampled
	logic seen_reset = 1'b0;

	// assertion failures, read by the testbench top
	int fail_cnt = 0;

	always @(posedge clk) begin
		if (edge_cnt != 2'd3) begin
			edge_cnt <= edge_cnt + 2'd1;
		end
		if (!rst_n) begin
			seen_reset <= 1'b1;
		end
	end

	// reset clears q, the cleared sum keeps it 0 one edge longer
	reset_clears_q: assert property (@(posedge clk)
		(edge_cnt >= 2'd2 && !$past(rst_n, 2)) |-> (q == '0))
		else begin
			$error("q is not zero two edges after reset was sampled low");
			fail_cnt++;
		end

	// sclr empties taps and sum, scaled zero reaches q on the next edge
	sclr_clears_q: assert property (@(posedge clk)
		(seen_reset && edge_cnt >= 2'd2 && $past(sclr, 2) && $past(d, 1) == '0)
		|-> (q == '0))
		else begin
			$error("q is not zero two edges after sclr with d held at zero");
			fail_cnt++;
		end

	// every stage is cleared by reset, so q stays known afterwards
	q_known: assert property (@(posedge clk) seen_reset |-> !$isunknown(q))
		else begin
			$error("q went unknown after reset");
			fail_cnt++;
		end

endmodule

// attach to every instance of the top level
bind moving_avg_top moving_avg_asserts #(
	.DATA_W(DATA_W)
) u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.sclr(sclr),
	.d(d),
	.q(q)
);

/* tb/avg_checker.sv */
`timescale 1ns/10ps

module avg_checker import maf_pkg::*; #(
	parameter int DATA_W = 24
) (
	input logic clk,
	input logic rst_n,
	input logic sclr,
	input logic [2:0] filt_sel,
	input logic signed [DATA_W-1:0] d,
	input logic signed [DATA_W-1:0] q,
	output int checks,
	output int errors
);

	// model history, index 0 newest
	logic signed [DATA_W-1:0] hist [HIST_DEPTH];

	// expected q, stage 2 is due at this edge
	logic signed [DATA_W-1:0] exp_pipe [3];

	// outputs still to be ignored after a change
	int skip = 3;
	int check_cnt = 0;
	int error_cnt = 0;
	logic [2:0] prev_sel = 3'b000;

	assign checks = check_cnt;
	assign errors = error_cnt;

	// select code to window length
	function automatic int window_len(input logic [2:0] sel);
		case (sel)
			3'b000: return 2;
			3'b001: return 3;
			3'b010: return 4;
			3'b011: return 8;
			default: return 16;
		endcase
	endfunction

	// average of the newest len samples
	function automatic logic signed [DATA_W-1:0] window_avg(input int len);
		longint acc;
		longint wl;
		longint avg;
		acc = 0;
		wl = longint'(len);
		for (int i = 0; i < len; i++) begin
			acc += longint'(hist[i]);
		end
		if (len == 3) begin
			// truncation toward zero
			avg = acc / wl;
		end else if (acc >= 0) begin
			avg = acc / wl;
		end else begin
			// floor for a negative sum
			avg = -((-acc + wl - 1) / wl);
		end
		return avg[DATA_W-1:0];
	endfunction

	always @(posedge clk) begin
		// q seen here was registered on the previous edge
		if (skip > 0) begin
			skip--;
		end else begin
			check_cnt++;
			if (q !== exp_pipe[2]) begin
				error_cnt++;
				$display("Error: time %0t ns, q expected %0d, actual %0d",
					$time, exp_pipe[2], q);
			end
		end
		// sample capture at this edge
		if (!rst_n || sclr) begin
			for (int i = 0; i < HIST_DEPTH; i++) begin
				hist[i] = '0;
			end
		end else begin
			for (int i = HIST_DEPTH - 1; i > 0; i--) begin
				hist[i] = hist[i-1];
			end
			hist[0] = d;
		end
		// two edges from capture to q
		exp_pipe[2] = exp_pipe[1];
		exp_pipe[1] = exp_pipe[0];
		exp_pipe[0] = window_avg(window_len(filt_sel));
		if (!rst_n) begin
			skip = 3;
			// decode comes out of reset on the 2 window
			prev_sel = 3'b000;
		end else begin
			if (sclr && skip < 2) begin
				skip = 2;
			end
			if (filt_sel != prev_sel) begin
				skip = 3;
			end
			prev_sel = filt_sel;
		end
	end

endmodule

/* tb/tb_moving_avg.sv */
`timescale 1ns/10ps

module tb_moving_avg;

	localparam int DATA_W = 24;
	localparam int CLK_NS = 8;
	localparam int NUM_ROWS = 22;
	localparam int FLUSH = 4;

	typedef enum logic [2:0] {
		KIND_CONST,
		KIND_RAMP,
		KIND_RANDOM,
		KIND_IMPULSE,
		KIND_EXTREME
	} kind_e;

	// one stimulus row, clr pulses sclr before the samples
	typedef struct packed {
		logic [2:0] sel;
		int count;
		kind_e kind;
		int value;
		logic clr;
	} row_t;

	// extreme rows use the sign of value to pick max or min
	localparam row_t ROWS [NUM_ROWS] = '{
		'{3'b000, 20, KIND_CONST, 1000, 1'b1},
		'{3'b001, 20, KIND_CONST, -777, 1'b0},
		'{3'b010, 20, KIND_CONST, 4242, 1'b0},
		'{3'b011, 20, KIND_CONST, -31, 1'b0},
		'{3'b100, 24, KIND_CONST, 65535, 1'b0},
		'{3'b101, 24, KIND_CONST, -65536, 1'b0},
		'{3'b110, 24, KIND_CONST, 12, 1'b0},
		'{3'b111, 24, KIND_CONST, -5, 1'b0},
		'{3'b000, 40, KIND_RANDOM, 0, 1'b1},
		'{3'b001, 40, KIND_RANDOM, 0, 1'b0},
		'{3'b010, 40, KIND_RANDOM, 0, 1'b0},
		'{3'b011, 40, KIND_RANDOM, 0, 1'b0},
		'{3'b100, 40, KIND_RANDOM, 0, 1'b0},
		'{3'b100, 30, KIND_RANDOM, 0, 1'b1},
		'{3'b001, 30, KIND_RAMP, -50, 1'b0},
		'{3'b000, 8, KIND_IMPULSE, 5, 1'b1},
		'{3'b001, 12, KIND_IMPULSE, -1000, 1'b1},
		'{3'b010, 12, KIND_IMPULSE, -7, 1'b1},
		'{3'b011, 16, KIND_IMPULSE, 9, 1'b1},
		'{3'b100, 24, KIND_IMPULSE, -17, 1'b1},
		'{3'b100, 24, KIND_EXTREME, 1, 1'b1},
		'{3'b111, 24, KIND_EXTREME, -1, 1'b0}
	};

	logic clk;
	logic rst_n;
	logic sclr;
	logic [2:0] filt_sel;
	logic signed [DATA_W-1:0] d;
	logic signed [DATA_W-1:0] q;
	logic [31:0] rng_state;
	int checks;
	int errors;

	moving_avg_top #(
		.DATA_W(DATA_W)
	) uut (
		.clk(clk),
		.rst_n(rst_n),
		.sclr(sclr),
		.filt_sel(filt_sel),
		.d(d),
		.q(q)
	);

	avg_checker #(
		.DATA_W(DATA_W)
	) u_check (
		.clk(clk),
		.rst_n(rst_n),
		.sclr(sclr),
		.filt_sel(filt_sel),
		.d(d),
		.q(q),
		.checks(checks),
		.errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_NS / 2) clk = ~clk;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// clocks the table needs, clear cycles included
	function automatic int total_samples();
		int n;
		n = 0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			n += ROWS[i].count + (ROWS[i].clr ? 1 : 0);
		end
		return n;
	endfunction

	task automatic make_sample(input row_t r, input int idx,
		output logic signed [DATA_W-1:0] s);
		case (r.kind)
			KIND_RAMP: s = DATA_W'(r.value + idx);
			KIND_RANDOM: begin
				rng_state = xorshift32(rng_state);
				s = rng_state[DATA_W-1:0];
			end
			// single spike on the second sample of the row
			KIND_IMPULSE: s = (idx == 1) ? DATA_W'(r.value) : '0;
			KIND_EXTREME: begin
				if (r.value >= 0) begin
					s = {1'b0, {(DATA_W-1){1'b1}}};
				end else begin
					s = {1'b1, {(DATA_W-1){1'b0}}};
				end
			end
			default: s = DATA_W'(r.value);
		endcase
	endtask

	// inputs change just after the edge
	task automatic drive_sample(input logic [2:0] sel,
		input logic signed [DATA_W-1:0] val, input logic clr);
		@(posedge clk);
		#1;
		filt_sel = sel;
		d = val;
		sclr = clr;
	endtask

	task automatic report_and_finish(input int timeouts);
		int total_err;
		total_err = errors + uut.u_asserts.fail_cnt;
		if (checks == 0) begin
			$display("no output of the filter was compared");
			total_err++;
		end
		$display("checks %0d, errors %0d, timeouts %0d", checks, total_err, timeouts);
		if (total_err == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	initial begin
		logic signed [DATA_W-1:0] s;
		rng_state = 32'd39548;
		rst_n = 1'b0;
		sclr = 1'b0;
		filt_sel = 3'b000;
		d = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (ROWS[r].clr) begin
				drive_sample(ROWS[r].sel, '0, 1'b1);
			end
			for (int i = 0; i < ROWS[r].count; i++) begin
				make_sample(ROWS[r], i, s);
				drive_sample(ROWS[r].sel, s, 1'b0);
			end
		end
		// let the last samples reach q
		repeat (FLUSH) drive_sample(ROWS[NUM_ROWS-1].sel, '0, 1'b0);
		report_and_finish(0);
	end

	// watchdog, twice the table length plus a margin
	initial begin
		int limit_ns;
		limit_ns = total_samples() * CLK_NS * 2 + 1000;
		#(limit_ns);
		$display("run timed out after %0d ns before the stimulus table finished", limit_ns);
		report_and_finish(1);
	end

endmodule

/* sources.f */
source/maf_pkg.sv
source/filt_cfg_if.sv
source/window_decode.sv
source/tap_sum.sv
source/avg_scale.sv
source/moving_avg_top.sv
tb/moving_avg_asserts.sv
tb/avg_checker.sv
tb/tb_moving_avg.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         := tb_moving_avg
FILELIST    := sources.f
OBJ_DIR     := obj_dir
LOG         := sim.log
PASS_MSG    := TESTS PASSED

COMMON_FLAGS := --timing --assert --timescale 1ns/10ps -f $(FILELIST) --top-module $(TOP)
LINT_FLAGS   := --lint-only $(COMMON_FLAGS)
BUILD_FLAGS  := --binary -j 0 --Mdir $(OBJ_DIR) $(COMMON_FLAGS)
# keep running after an assertion error so the testbench can report
RUN_ARGS     := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

sim:
	$(VERILATOR) $(BUILD_FLAGS)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
